// ==== hdl/board_pkg.sv ====
package board_pkg;

    // Two bits per board cell, the same codes the software side uses.
    typedef logic [1:0] cell_t;

    localparam cell_t CELL_BLACK = 2'd0;
    localparam cell_t CELL_WHITE = 2'd1;
    localparam cell_t CELL_EMPTY = 2'd2;

    typedef logic [3:0] coord_t;   // Wide enough for a 16x16 board.

    // Scan directions, in the order the sequencer walks them.
    typedef enum logic [1:0] {
        DIR_VERT,
        DIR_HORZ,
        DIR_DIAG_DR,
        DIR_DIAG_DL
    } dir_t;

    // One anchor cell of the scan.
    typedef struct packed {
        logic   valid;
        dir_t   dir;
        coord_t row;
        coord_t col;
        logic   last;
    } step_t;

    // Six cells read from an anchor outward, cells[0] being the anchor.
    // in5 and in6 are set when the first five or all six cells lie on the board.
    typedef struct packed {
        logic        valid;
        logic        last;
        cell_t [0:5] cells;
        logic        in5;
        logic        in6;
    } window_t;

endpackage

// ==== hdl/pattern_pkg.sv ====
package pattern_pkg;

    import board_pkg::*;

    typedef logic signed [31:0] score_t;
    typedef logic [31:0]        weight_t;

    // Black and white weight sums for one window.
    typedef struct packed {
        logic    valid;
        logic    last;
        weight_t black;
        weight_t white;
    } match_t;

    localparam weight_t FIVE          = 32'd1000000;
    localparam weight_t FOUR          = 32'd100000;
    localparam weight_t BLOCKED_FOUR  = 32'd10000;
    localparam weight_t THREE         = 32'd1000;
    localparam weight_t TWO           = 32'd100;
    localparam weight_t BLOCKED_THREE = 32'd100;
    localparam weight_t BLOCKED_TWO   = 32'd10;

    localparam int N_FIVE = 10;
    localparam int N_SIX  = 19;

    localparam cell_t B = CELL_BLACK;
    localparam cell_t W = CELL_WHITE;
    localparam cell_t E = CELL_EMPTY;

    // Black shapes only. White is matched on a colour-swapped window.
    localparam logic [9:0] SHAPES5 [N_FIVE] = '{
        {B, B, B, B, B},
        {E, B, B, B, E},
        {E, B, E, B, E},
        {B, E, B, B, B},
        {B, B, B, E, B},
        {B, B, E, B, B},
        {B, E, E, B, B},
        {B, B, E, E, B},
        {B, E, B, E, B},
        {B, E, E, E, B}
    };

    localparam weight_t WEIGHTS5 [N_FIVE] = '{
        FIVE, THREE, TWO, BLOCKED_FOUR, BLOCKED_FOUR, BLOCKED_FOUR,
        BLOCKED_THREE, BLOCKED_THREE, BLOCKED_THREE, BLOCKED_TWO
    };

    localparam logic [11:0] SHAPES6 [N_SIX] = '{
        {E, B, B, B, B, E},
        {E, B, E, B, B, E},
        {E, B, B, E, B, E},
        {E, E, B, B, E, E},
        {E, B, E, E, B, E},
        {E, B, B, B, B, W},
        {W, B, B, B, B, E},
        {E, E, B, B, B, W},
        {W, B, B, B, E, E},
        {E, B, E, B, B, W},
        {W, B, B, E, B, E},
        {E, B, B, E, B, W},
        {W, B, E, B, B, E},
        {E, E, E, B, B, W},
        {W, B, B, E, E, E},
        {E, E, B, E, B, W},
        {W, B, E, B, E, E},
        {E, B, E, E, B, W},
        {W, B, E, E, B, E}
    };

    localparam weight_t WEIGHTS6 [N_SIX] = '{
        FOUR, THREE, THREE, TWO, TWO, BLOCKED_FOUR, BLOCKED_FOUR,
        BLOCKED_THREE, BLOCKED_THREE, BLOCKED_THREE, BLOCKED_THREE,
        BLOCKED_THREE, BLOCKED_THREE, BLOCKED_TWO, BLOCKED_TWO,
        BLOCKED_TWO, BLOCKED_TWO, BLOCKED_TWO, BLOCKED_TWO
    };

    // Black becomes white and white becomes black, empty cells stay.
    function automatic logic [11:0] swap_colour(input logic [11:0] cells);
        logic [11:0] swapped;
        swapped = cells;
        for (int i = 0; i < 6; i++) begin
            if (cells[2*i +: 2] == CELL_BLACK) begin
                swapped[2*i +: 2] = CELL_WHITE;
            end else if (cells[2*i +: 2] == CELL_WHITE) begin
                swapped[2*i +: 2] = CELL_BLACK;
            end
        end
        return swapped;
    endfunction

endpackage

// ==== hdl/scan_sequencer.sv ====
`timescale 1ns/100ps

module scan_sequencer #(
    parameter int BOARD_DIM = 15
) (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             start_i,
    output board_pkg::step_t step_o
);

    import board_pkg::*;

    localparam coord_t LAST_IDX = coord_t'(BOARD_DIM - 1);

    typedef enum logic {
        S_IDLE,
        S_SCAN
    } state_t;

    state_t state_r;
    step_t  step_r;
    step_t  step_next;

    // Next anchor: the first one when idle, otherwise row-major within a direction.
    always_comb begin
        step_next = step_r;
        if (state_r == S_IDLE) begin
            step_next.dir = DIR_VERT;
            step_next.row = '0;
            step_next.col = '0;
        end else if (step_r.col != LAST_IDX) begin
            step_next.col = step_r.col + 1'b1;
        end else begin
            step_next.col = '0;
            if (step_r.row != LAST_IDX) begin
                step_next.row = step_r.row + 1'b1;
            end else begin
                step_next.row = '0;
                step_next.dir = dir_t'(step_r.dir + 2'd1);
            end
        end
        step_next.valid = 1'b1;
        step_next.last  = (step_next.dir == DIR_DIAG_DL) &&
                          (step_next.row == LAST_IDX) &&
                          (step_next.col == LAST_IDX);
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_r <= S_IDLE;
            step_r  <= '0;
        end else begin
            case (state_r)
                S_IDLE: begin
                    if (start_i) begin
                        state_r <= S_SCAN;
                        step_r  <= step_next;
                    end
                end
                default: begin
                    if (step_r.last) begin
                        state_r      <= S_IDLE;   // Start is ignored until here.
                        step_r.valid <= 1'b0;
                        step_r.last  <= 1'b0;
                    end else begin
                        step_r <= step_next;
                    end
                end
            endcase
        end
    end

    assign step_o = step_r;

    a_idle_no_step: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (state_r == S_IDLE) |-> !step_o.valid);

endmodule

// ==== hdl/window_gather.sv ====
`timescale 1ns/100ps

module window_gather #(
    parameter int BOARD_DIM = 15
) (
    input  logic                                          i_clk,
    input  logic                                          i_rst_n,
    input  board_pkg::step_t                              step_i,
    input  board_pkg::cell_t [BOARD_DIM*BOARD_DIM-1:0]    board_i,
    output board_pkg::window_t                            window_o
);

    import board_pkg::*;

    logic [5:0]  on_board;
    cell_t [0:5] cells;

    logic        valid_r;
    logic        last_r;
    cell_t [0:5] cells_r;
    logic        in5_r;
    logic        in6_r;

    always_comb begin
        int r;
        int c;
        int idx;
        for (int i = 0; i < 6; i++) begin
            r = int'(step_i.row);
            c = int'(step_i.col);
            case (step_i.dir)
                DIR_VERT: r = r + i;
                DIR_HORZ: c = c + i;
                DIR_DIAG_DR: begin
                    r = r + i;
                    c = c + i;
                end
                default: begin
                    r = r + i;   // Down-left walks one column back per row.
                    c = c - i;
                end
            endcase
            on_board[i] = (r < BOARD_DIM) && (c >= 0) && (c < BOARD_DIM);
            idx         = on_board[i] ? r * BOARD_DIM + c : 0;
            cells[i]    = on_board[i] ? board_i[idx] : CELL_EMPTY;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            valid_r <= 1'b0;
            last_r  <= 1'b0;
        end else begin
            valid_r <= step_i.valid;
            last_r  <= step_i.valid && step_i.last;
        end
    end

    always_ff @(posedge i_clk) begin
        cells_r <= cells;
        in5_r   <= &on_board[4:0];
        in6_r   <= &on_board;
    end

    assign window_o = '{valid: valid_r, last: last_r, cells: cells_r, in5: in5_r, in6: in6_r};

    a_valid_anchor: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        window_o.valid |->
            (int'($past(step_i.row)) < BOARD_DIM) && (int'($past(step_i.col)) < BOARD_DIM));

endmodule

// ==== hdl/pattern_matcher.sv ====
`timescale 1ns/100ps

module pattern_matcher (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  board_pkg::window_t   window_i,
    output pattern_pkg::match_t  match_o
);

    import pattern_pkg::*;

    weight_t black_sum;
    weight_t white_sum;

    logic    valid_r;
    logic    last_r;
    weight_t black_r;
    weight_t white_r;

    // Sum of black shape weights found in six cells, cells[11:10] being the anchor.
    function automatic weight_t score_cells(
        input logic [11:0] cells,
        input logic        in5,
        input logic        in6
    );
        weight_t sum;
        sum = '0;
        for (int k = 0; k < N_FIVE; k++) begin
            if (in5 && (cells[11:2] == SHAPES5[k])) begin
                sum = sum + WEIGHTS5[k];
            end
        end
        for (int k = 0; k < N_SIX; k++) begin
            if (in6 && (cells == SHAPES6[k])) begin
                sum = sum + WEIGHTS6[k];
            end
        end
        return sum;
    endfunction

    always_comb begin
        black_sum = score_cells(window_i.cells, window_i.in5, window_i.in6);
        // White shapes are black shapes with the colours exchanged.
        white_sum = score_cells(swap_colour(window_i.cells), window_i.in5, window_i.in6);
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            valid_r <= 1'b0;
            last_r  <= 1'b0;
        end else begin
            valid_r <= window_i.valid;
            last_r  <= window_i.valid && window_i.last;
        end
    end

    always_ff @(posedge i_clk) begin
        black_r <= black_sum;
        white_r <= white_sum;
    end

    assign match_o = '{valid: valid_r, last: last_r, black: black_r, white: white_r};

endmodule

// ==== hdl/score_accumulator.sv ====
`timescale 1ns/100ps

module score_accumulator (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 start_i,
    input  pattern_pkg::match_t  match_i,
    output pattern_pkg::score_t  score_o,
    output logic                 finish_o
);

    import pattern_pkg::*;

    weight_t black_acc_r;
    weight_t white_acc_r;
    logic    last_seen_r;   // The final match has been added.
    score_t  score_r;
    logic    finish_r;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            black_acc_r <= '0;
            white_acc_r <= '0;
            last_seen_r <= 1'b0;
            score_r     <= '0;
            finish_r    <= 1'b0;
        end else begin
            last_seen_r <= match_i.valid && match_i.last;
            finish_r    <= last_seen_r;
            if (last_seen_r) begin
                score_r <= score_t'(black_acc_r - white_acc_r);
            end
            if (start_i) begin
                black_acc_r <= '0;
                white_acc_r <= '0;
            end else if (match_i.valid) begin
                black_acc_r <= black_acc_r + match_i.black;
                white_acc_r <= white_acc_r + match_i.white;
            end
        end
    end

    // Score holds between finishes.
    assign score_o  = score_r;
    assign finish_o = finish_r;

    a_finish_single: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        finish_o |=> !finish_o);

endmodule

// ==== hdl/board_evaluator.sv ====
`timescale 1ns/100ps

module board_evaluator #(
    parameter int BOARD_DIM = 15
) (
    input  logic                                          i_clk,
    input  logic                                          i_rst_n,
    input  logic                                          start_i,
    input  board_pkg::cell_t [BOARD_DIM*BOARD_DIM-1:0]    board_i,
    output pattern_pkg::score_t                           score_o,
    output logic                                          finish_o
);

    import board_pkg::*;
    import pattern_pkg::*;

    step_t   seq_step;
    window_t gathered_window;
    match_t  matched;

    // One anchor per cycle, three register stages behind the sequencer.
    scan_sequencer #(
        .BOARD_DIM (BOARD_DIM)
    ) u_scan_sequencer (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .start_i (start_i),
        .step_o  (seq_step)
    );

    window_gather #(
        .BOARD_DIM (BOARD_DIM)
    ) u_window_gather (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .step_i   (seq_step),
        .board_i  (board_i),        // Must stay steady for the whole scan.
        .window_o (gathered_window)
    );

    pattern_matcher u_pattern_matcher (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .window_i (gathered_window),
        .match_o  (matched)
    );

    score_accumulator u_score_accumulator (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .start_i  (start_i),
        .match_i  (matched),
        .score_o  (score_o),
        .finish_o (finish_o)
    );

endmodule

// ==== tests/tb_board_evaluator.sv ====
`timescale 1ns/100ps

module tb_board_evaluator;

    import board_pkg::*;

    localparam int BOARD_DIM = 15;
    localparam int N_CELLS   = BOARD_DIM * BOARD_DIM;
    localparam int LATENCY   = 4 * BOARD_DIM * BOARD_DIM + 3;   // Start edge to finish edge.
    localparam int TIMEOUT   = 2 * LATENCY;
    localparam int N_CASES   = 14;

    localparam int W_FOUR         = 100000;
    localparam int W_BLOCKED_FOUR = 10000;
    localparam int W_TWO          = 100;

    typedef enum logic [2:0] {
        SH_NONE,
        SH_OPEN_FOUR,
        SH_OPEN_TWO,
        SH_BLOCKED_FOUR,
        SH_FOUR_PAIR
    } shape_e;

    typedef struct packed {
        shape_e             shape;
        logic               white;   // Colour of the main shape.
        dir_t               dir;
        logic signed [31:0] expected;
    } case_t;

    logic                i_clk;
    logic                i_rst_n;
    logic                start_i;
    cell_t [N_CELLS-1:0] board;
    logic signed [31:0]  score_o;
    logic                finish_o;

    case_t              cases [N_CASES];
    logic [15:0]        lfsr_state;
    int                 value_errors;
    int                 timeouts;
    logic signed [31:0] held_score;

    board_evaluator #(
        .BOARD_DIM (BOARD_DIM)
    ) u_dut (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .start_i  (start_i),
        .board_i  (board),
        .score_o  (score_o),
        .finish_o (finish_o)
    );

    always #10 i_clk = ~i_clk;

    // Galois form of x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    task automatic draw_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            value      = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    task automatic fill_cases();
        cases[0]  = '{SH_NONE,         1'b0, DIR_VERT,    0};
        cases[1]  = '{SH_OPEN_FOUR,    1'b0, DIR_VERT,    W_FOUR};
        cases[2]  = '{SH_OPEN_FOUR,    1'b0, DIR_HORZ,    W_FOUR};
        cases[3]  = '{SH_OPEN_FOUR,    1'b0, DIR_DIAG_DR, W_FOUR};
        cases[4]  = '{SH_OPEN_FOUR,    1'b0, DIR_DIAG_DL, W_FOUR};
        cases[5]  = '{SH_OPEN_FOUR,    1'b1, DIR_VERT,    -W_FOUR};
        cases[6]  = '{SH_OPEN_FOUR,    1'b1, DIR_DIAG_DL, -W_FOUR};
        cases[7]  = '{SH_OPEN_TWO,     1'b0, DIR_HORZ,    W_TWO};
        cases[8]  = '{SH_OPEN_TWO,     1'b0, DIR_DIAG_DR, W_TWO};
        cases[9]  = '{SH_FOUR_PAIR,    1'b0, DIR_HORZ,    0};
        cases[10] = '{SH_BLOCKED_FOUR, 1'b0, DIR_VERT,    W_BLOCKED_FOUR};
        cases[11] = '{SH_BLOCKED_FOUR, 1'b0, DIR_DIAG_DL, W_BLOCKED_FOUR};
        cases[12] = '{SH_BLOCKED_FOUR, 1'b1, DIR_HORZ,    -W_BLOCKED_FOUR};
        cases[13] = '{SH_NONE,         1'b0, DIR_HORZ,    0};   // Sums must restart.
    endtask

    // Writes six cells from (row, col) outward along dir.
    task automatic place_line(input int row, input int col, input dir_t dir,
                              input cell_t [0:5] line);
        int dr;
        int dc;
        dr = (dir == DIR_HORZ) ? 0 : 1;
        dc = (dir == DIR_VERT) ? 0 : ((dir == DIR_DIAG_DL) ? -1 : 1);
        for (int i = 0; i < 6; i++) begin
            board[(row + dr * i) * BOARD_DIM + col + dc * i] = line[i];
        end
    endtask

    task automatic load_case(input case_t tc);
        int          pick;
        int          row;
        int          col;
        cell_t       own;
        cell_t       opp;
        cell_t [0:5] four_own;
        cell_t [0:5] four_opp;
        board = {N_CELLS{CELL_EMPTY}};
        draw_bits(3, pick);
        row = 2 + pick % 6;
        draw_bits(3, pick);
        col = (tc.dir == DIR_DIAG_DL) ? BOARD_DIM - 3 - pick % 6 : 2 + pick % 6;
        own = tc.white ? CELL_WHITE : CELL_BLACK;
        opp = tc.white ? CELL_BLACK : CELL_WHITE;
        four_own = {CELL_EMPTY, own, own, own, own, CELL_EMPTY};
        four_opp = {CELL_EMPTY, opp, opp, opp, opp, CELL_EMPTY};
        case (tc.shape)
            SH_OPEN_FOUR: place_line(row, col, tc.dir, four_own);
            SH_OPEN_TWO: begin
                place_line(row, col, tc.dir,
                           {CELL_EMPTY, CELL_EMPTY, own, own, CELL_EMPTY, CELL_EMPTY});
            end
            SH_BLOCKED_FOUR: place_line(row, col, tc.dir, {opp, own, own, own, own, CELL_EMPTY});
            SH_FOUR_PAIR: begin
                // Both fours lie along rows, so no window holds two stones of the other line.
                place_line(row, col, tc.dir, four_own);
                place_line(row + 6, col, tc.dir, four_opp);
            end
            default: ;
        endcase
    endtask

    task automatic run_scan(input int n, input logic signed [31:0] expected,
                            output logic timed_out);
        int cycles;
        start_i = 1'b1;
        @(negedge i_clk);
        start_i   = 1'b0;
        cycles    = 0;
        timed_out = 1'b0;
        while (!finish_o && cycles < TIMEOUT) begin
            assert (score_o === held_score) else begin
                value_errors++;
                $display("error at %0t: score_o is %0d, expected held %0d", $time,
                         score_o, held_score);
            end
            @(negedge i_clk);
            cycles++;
        end
        if (!finish_o) begin
            timed_out = 1'b1;
            timeouts++;
            $display("timeout: case %0d saw no finish within %0d cycles of start", n, TIMEOUT);
        end else begin
            assert (cycles == LATENCY) else begin
                value_errors++;
                $display("error at %0t: finish_o latency is %0d, expected %0d", $time,
                         cycles, LATENCY);
            end
            assert (score_o === expected) else begin
                value_errors++;
                $display("error at %0t: score_o is %0d, expected %0d in case %0d", $time,
                         score_o, expected, n);
            end
            held_score = expected;
            repeat (4) @(negedge i_clk);
            assert (score_o === held_score) else begin
                value_errors++;
                $display("error at %0t: score_o is %0d, expected held %0d", $time,
                         score_o, held_score);
            end
        end
    endtask

    initial begin
        logic timed_out;
        i_clk        = 1'b0;
        i_rst_n      = 1'b0;
        start_i      = 1'b0;
        board        = {N_CELLS{CELL_EMPTY}};
        lfsr_state   = 16'd27381;
        value_errors = 0;
        timeouts     = 0;
        held_score   = 0;
        timed_out    = 1'b0;
        fill_cases();
        repeat (16) @(negedge i_clk);
        i_rst_n = 1'b1;
        @(negedge i_clk);
        assert (score_o === 0 && finish_o === 1'b0) else begin
            value_errors++;
            $display("error at %0t: score_o is %0d and finish_o is %0b, expected 0 and 0",
                     $time, score_o, finish_o);
        end
        for (int n = 0; n < N_CASES && !timed_out; n++) begin
            load_case(cases[n]);
            run_scan(n, cases[n].expected, timed_out);
        end
        $display("checks done: %0d value errors, %0d timeouts", value_errors, timeouts);
        if (value_errors == 0 && timeouts == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== board_evaluator.f ====
hdl/board_pkg.sv
hdl/pattern_pkg.sv
hdl/scan_sequencer.sv
hdl/window_gather.sv
hdl/pattern_matcher.sv
hdl/score_accumulator.sv
hdl/board_evaluator.sv
tests/tb_board_evaluator.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log for the pass line.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_board_evaluator -f board_evaluator.f \
    -o tb_board_evaluator > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_board_evaluator > sim.log 2>&1 ; cat sim.log

grep -qx "ALL TESTS PASSED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
